// ==== dv/xgmii_tx_tb.sv ====
// testbench with frame table, reference CRC-32, XGMII monitor, compare tasks and timeout
`timescale 1ns/1ps
`include "xgmii_tx_macros.svh"

module xgmii_tx_tb
    import xgmii_tx_pkg::*;
();

    localparam int num_frames = 11;
    localparam int max_len = 256;
    localparam xgmii_word_t idle_word = '{txd: {8{8'h07}}, txc: 8'hFF};
    localparam xgmii_word_t start_word = '{txd: {`ETH_SFD, {6{`ETH_PRE}}, 8'hFB}, txc: 8'h01};
    localparam xgmii_word_t err_word = '{txd: {8'hFD, {7{8'hFE}}}, txc: 8'hFF};

    typedef struct packed {
        int len;
        bit user;
        int uf_beat;
        int ifg;
        bit enable;
    } frame_spec_t;

    typedef logic [7:0] byte_q_t [$];

    logic clk;
    logic reset_crc;
    tx_beat_t s_beat;
    logic s_valid;
    logic s_ready;
    logic [7:0] tx_ifg;
    logic tx_enable;
    xgmii_word_t xgmii;
    tx_stat_t stat;

    frame_spec_t frames [num_frames];
    logic [7:0] payload [num_frames][max_len];
    int seed;
    int error_count = 0;
    int check_count = 0;
    int done_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    // monitor state
    bit in_frame = 1'b0;
    int frame_idx = 0;
    int gap_bytes = 0;
    int frame_errs = 0;
    byte_q_t rx_q;

    xgmii_tx_top xgmii_tx_top_inst (
        .clk       (clk),
        .reset_crc (reset_crc),
        .s_beat    (s_beat),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .tx_ifg    (tx_ifg),
        .tx_enable (tx_enable),
        .xgmii     (xgmii),
        .stat      (stat)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int min_gap(input int ifg);
        return (ifg > `ETH_MIN_IFG) ? ifg : `ETH_MIN_IFG;
    endfunction

    function automatic int beat_count(input int len);
        return (len + 7) / 8;
    endfunction

    // bit serial, lsb first
    function automatic logic [31:0] frame_crc(input byte_q_t bytes);
        logic [31:0] c;
        logic fb;
        c = `ETH_CRC_INIT;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ bytes[i][b];
                c = c >> 1;
                if (fb) begin
                    c = c ^ `ETH_CRC_POLY;
                end
            end
        end
        return ~c;
    endfunction

    function automatic tx_beat_t make_beat(input int k, input int b);
        tx_beat_t beat;
        int idx;
        beat = '0;
        for (int l = 0; l < 8; l++) begin
            idx = 8 * b + l;
            if (idx < frames[k].len) begin
                beat.data[8*l +: 8] = payload[k][idx];
                beat.keep[l] = 1'b1;
            end else begin
                // junk behind keep, must never reach the line
                beat.data[8*l +: 8] = 8'(idx) ^ 8'hC3;
            end
        end
        beat.last = (b == beat_count(frames[k].len) - 1);
        beat.user = frames[k].user && (b == beat_count(frames[k].len) / 2);
        return beat;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic check_word(input string name, input xgmii_word_t got, input xgmii_word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_stat(input string name, input tx_stat_t got, input tx_stat_t exp,
                              input bit check_len);
        check_count++;
        if (check_len ? (got !== exp) : (got[4:0] !== exp[4:0])) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // drop enable, then line must stay idle with s_ready low
    task automatic hold_disabled(input int n);
        @(posedge clk);
        tx_enable <= 1'b0;
        repeat (2) @(posedge clk);
        repeat (n) begin
            @(negedge clk);
            if (s_ready !== 1'b0) begin
                report_error($sformatf("mismatch s_ready: got %h expected 0", s_ready));
            end
            check_word("xgmii while disabled", xgmii, idle_word);
        end
        @(posedge clk);
        tx_enable <= 1'b1;
    endtask

    task automatic send_frame(input int k);
        int nb;
        int i;
        bit gapped;
        nb = beat_count(frames[k].len);
        i = 0;
        gapped = 1'b0;
        // entered on a rising edge, so the first beat is offered at once
        while (i < nb) begin
            if (i == frames[k].uf_beat && !gapped) begin
                s_valid <= 1'b0;
                gapped = 1'b1;
            end else begin
                s_valid <= 1'b1;
                s_beat <= make_beat(k, i);
            end
            @(negedge clk);
            if (s_valid && s_ready) begin
                i++;
            end
            @(posedge clk);
        end
        s_valid <= 1'b0;
    endtask

    task automatic finish_frame(input bit bad);
        frame_spec_t spec;
        byte_q_t exp_q;
        tx_stat_t exp_stat;
        logic [31:0] crc;
        int plen;
        spec = frames[frame_idx];
        exp_stat = '0;
        exp_stat.valid = 1'b1;
        if (bad != (spec.user || spec.uf_beat >= 0)) begin
            report_error($sformatf("frame %0d ended with the wrong kind of end", frame_idx));
        end
        if (bad) begin
            exp_stat.pkt_bad = 1'b1;
            exp_stat.err_user = spec.user;
            exp_stat.err_underflow = !spec.user;
            if (rx_q.size() >= spec.len) begin
                report_error($sformatf("frame %0d: error word after the whole payload", frame_idx));
            end
            for (int i = 0; i < rx_q.size() && i < spec.len; i++) begin
                check_byte($sformatf("rx byte %0d", i), rx_q[i], payload[frame_idx][i]);
            end
        end else begin
            plen = (spec.len > `ETH_MIN_FRAME_LEN - 4) ? spec.len : `ETH_MIN_FRAME_LEN - 4;
            for (int i = 0; i < plen; i++) begin
                exp_q.push_back((i < spec.len) ? payload[frame_idx][i] : 8'h00);
            end
            crc = frame_crc(exp_q);
            for (int i = 0; i < 4; i++) begin
                exp_q.push_back(crc[8*i +: 8]);
            end
            exp_stat.pkt_good = 1'b1;
            exp_stat.pkt_len = 16'(plen + 4);
            if (rx_q.size() != exp_q.size()) begin
                report_error($sformatf("frame %0d: %0d bytes on the line, expected %0d",
                                       frame_idx, rx_q.size(), exp_q.size()));
            end
            for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
                check_byte($sformatf("rx byte %0d", i), rx_q[i], exp_q[i]);
            end
        end
        if (stat.valid !== 1'b1) begin
            report_error($sformatf("frame %0d: no status pulse with the last word", frame_idx));
        end else begin
            check_stat("stat", stat, exp_stat, !bad);
        end
        $display("frame %0d (%0d bytes, ifg %0d): %s", frame_idx, spec.len, spec.ifg,
                 (error_count == frame_errs) ? "ok" : "error");
        frame_idx++;
        in_frame = 1'b0;
        done_count++;
    endtask

    // rebuilds the byte stream from every line word
    task automatic watch_word();
        logic [7:0] c;
        bit term_seen;
        bit ended;
        term_seen = 1'b0;
        ended = 1'b0;
        if (!in_frame) begin
            if (xgmii.txc[0] && xgmii.txd[7:0] == 8'hFB) begin
                frame_errs = error_count;
                check_word("xgmii start", xgmii, start_word);
                if (frame_idx >= num_frames) begin
                    report_error("frame start beyond the end of the table");
                end else begin
                    if (frame_idx > 0 && gap_bytes < min_gap(frames[frame_idx-1].ifg)) begin
                        report_error($sformatf("frame %0d: only %0d idle bytes before start",
                                               frame_idx, gap_bytes));
                    end
                    in_frame = 1'b1;
                    rx_q.delete();
                end
            end else begin
                for (int l = 0; l < 8; l++) begin
                    if (!xgmii.txc[l] || xgmii.txd[8*l +: 8] != 8'h07) begin
                        report_error($sformatf("lane %0d holds %h between frames, not idle",
                                               l, xgmii.txd[8*l +: 8]));
                    end
                end
                gap_bytes += 8;
            end
        end else if (xgmii.txc[0] && xgmii.txd[7:0] == 8'hFE) begin
            check_word("xgmii error word", xgmii, err_word);
            gap_bytes = 0;
            ended = 1'b1;
            finish_frame(1'b1);
        end else begin
            gap_bytes = 0;
            for (int l = 0; l < 8; l++) begin
                c = xgmii.txd[8*l +: 8];
                if (term_seen) begin
                    if (!xgmii.txc[l] || c != 8'h07) begin
                        report_error($sformatf("lane %0d after terminate is not idle", l));
                    end
                    gap_bytes++;
                end else if (!xgmii.txc[l]) begin
                    rx_q.push_back(c);
                end else if (c == 8'hFD) begin
                    term_seen = 1'b1;
                end else begin
                    report_error($sformatf("control %h in lane %0d inside a frame", c, l));
                end
            end
            if (term_seen) begin
                ended = 1'b1;
                finish_frame(1'b0);
            end
        end
        if (stat.valid === 1'b1 && !ended) begin
            report_error("status pulse without a frame end");
        end
    endtask

    always @(negedge clk) begin
        if (!reset_crc) begin
            watch_word();
        end
    end

    initial begin
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout with %0d of %0d frames done", done_count, num_frames);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int total;
        s_beat <= '0;
        s_valid <= 1'b0;
        tx_ifg <= 8'd12;
        tx_enable <= 1'b0;
        reset_crc <= 1'b1;
        seed = 15742;
        // len, user, underflow beat, ifg, enable
        frames = '{
            '{64, 1'b0, -1, 12, 1'b1},
            '{100, 1'b0, -1, 8, 1'b1},
            '{46, 1'b0, -1, 20, 1'b1},
            '{1, 1'b0, -1, 12, 1'b1},
            '{61, 1'b0, -1, 12, 1'b1},
            '{200, 1'b1, -1, 12, 1'b1},
            '{57, 1'b0, -1, 8, 1'b1},
            '{120, 1'b0, 3, 20, 1'b1},
            '{72, 1'b0, -1, 8, 1'b0},
            '{60, 1'b0, -1, 20, 1'b1},
            '{163, 1'b0, -1, 12, 1'b1}
        };
        total = 40;
        for (int k = 0; k < num_frames; k++) begin
            total += beat_count((frames[k].len > 60) ? frames[k].len : 60) + 8;
            total += min_gap(frames[k].ifg) / 8;
            if (!frames[k].enable) begin
                total += 12;
            end
            for (int i = 0; i < frames[k].len; i++) begin
                payload[k][i] = 8'($random(seed));
            end
        end
        cycle_limit = total + 100;
        repeat (4) @(posedge clk);
        reset_crc <= 1'b0;
        hold_disabled(6);
        for (int k = 0; k < num_frames; k++) begin
            if (!frames[k].enable) begin
                hold_disabled(4);
            end
            tx_ifg <= 8'(frames[k].ifg);
            send_frame(k);
            while (done_count <= k) begin
                @(posedge clk);
            end
        end
        repeat (4) @(posedge clk);
        $display("%0d frames, %0d checks, %0d errors", done_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module xgmii_tx_tb \
    -f xgmii_tx_top.f -Mdir obj_dir -o xgmii_tx_sim \
    && ./obj_dir/xgmii_tx_sim | tee /dev/stderr | grep -xF '*** PASSED ***' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== source/eth_crc32.sv ====
// byte-parallel CRC-32 engine with running state and registered partial results
`timescale 1ns/1ps
`include "xgmii_tx_macros.svh"

module eth_crc32
    import xgmii_tx_pkg::*;
(
    input  logic                     clk,
    input  logic                     crc_init,
    input  logic                     crc_update,
    input  logic [`XGMII_DATA_W-1:0] data,
    output crc_lanes_t               crc_next,
    output crc_lanes_t               crc_held
);

    // one byte, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] b);
        logic [31:0] c;
        c = crc_in ^ {24'd0, b};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ `ETH_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    // chain through the word, tapping after every byte
    always_comb begin
        logic [31:0] run;
        run = crc_held[`XGMII_CTRL_W-1];
        for (int n = 0; n < `XGMII_CTRL_W; n++) begin
            run = crc_byte(run, data[8*n +: 8]);
            crc_next[n] = run;
        end
    end

    // the full-word entry doubles as the running state
    always_ff @(posedge clk) begin
        if (crc_init) begin
            crc_held[`XGMII_CTRL_W-1] <= `ETH_CRC_INIT;
        end else if (crc_update) begin
            crc_held <= crc_next;
        end
    end

    // controller asserts these from disjoint states
    assert property (@(posedge clk) !(crc_init === 1'b1 && crc_update === 1'b1))
        else $error("crc_init and crc_update high in the same cycle");

endmodule

// ==== source/xgmii_fcs_merge.sv ====
// FCS placement after the last data byte, terminate insertion and idle fill
`timescale 1ns/1ps
`include "xgmii_tx_macros.svh"

module xgmii_fcs_merge
    import xgmii_tx_pkg::*;
(
    input  logic [`XGMII_DATA_W-1:0] data,
    input  logic [2:0]               empty,
    input  crc_lanes_t               crc_next,
    input  crc_lanes_t               crc_held,
    output fcs_words_t               fcs
);

    localparam int lanes = `XGMII_CTRL_W;

    always_comb begin
        int nb;
        int term_lane;
        logic [31:0] fcs_now;
        logic [31:0] fcs_reg;
        logic [2*lanes-1:0][7:0] lane_d;
        logic [2*lanes-1:0] lane_c;

        nb = lanes - int'(empty);
        term_lane = nb + 4;

        // bytes landing in the second word are sent a cycle later
        fcs_now = ~crc_next[nb-1];
        fcs_reg = ~crc_held[nb-1];

        lane_d = {{lanes{xgmii_idle}}, data};
        lane_c = {{lanes{1'b1}}, {lanes{1'b0}}};

        for (int i = 0; i < 2*lanes; i++) begin
            if (i >= nb && i < term_lane) begin
                if (i < lanes) begin
                    lane_d[i] = fcs_now[8*(i-nb) +: 8];
                end else begin
                    lane_d[i] = fcs_reg[8*(i-nb) +: 8];
                end
                lane_c[i] = 1'b0;
            end else if (i == term_lane) begin
                lane_d[i] = xgmii_term;
                lane_c[i] = 1'b1;
            end else if (i > term_lane) begin
                lane_d[i] = xgmii_idle;
                lane_c[i] = 1'b1;
            end
        end

        fcs.word_0.txd = lane_d[lanes-1:0];
        fcs.word_0.txc = lane_c[lanes-1:0];
        fcs.word_1.txd = lane_d[2*lanes-1:lanes];
        fcs.word_1.txc = lane_c[2*lanes-1:lanes];

        // terminate plus trailing idles in whichever word ends the frame
        if (term_lane < lanes) begin
            fcs.ifg_offset = 4'(lanes - term_lane);
        end else begin
            fcs.ifg_offset = 4'(2*lanes - term_lane);
        end
    end

endmodule

// ==== source/xgmii_tx_ctrl.sv ====
// framing FSM with padding, error drop, gap and length counters, status and XGMII register
`timescale 1ns/1ps
`include "xgmii_tx_macros.svh"

module xgmii_tx_ctrl
    import xgmii_tx_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_crc,
    input  tx_beat_t                 s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,
    input  logic [7:0]               tx_ifg,
    input  logic                     tx_enable,
    output logic [`XGMII_DATA_W-1:0] held_data,
    output logic [2:0]               held_empty,
    output logic                     crc_init,
    output logic                     crc_update,
    input  fcs_words_t               fcs,
    output xgmii_word_t              xgmii,
    output tx_stat_t                 stat
);

    localparam logic [7:0] min_payload = 8'(`ETH_MIN_FRAME_LEN - 4);
    localparam logic [7:0] word_bytes = 8'(`XGMII_CTRL_W);
    localparam xgmii_word_t idle_word = '{
        txd: {`XGMII_CTRL_W{xgmii_idle}},
        txc: {`XGMII_CTRL_W{1'b1}}
    };

    tx_state_e state;
    tx_state_e state_next;
    logic frame_open;
    logic frame_open_next;
    logic ready_next;
    logic handshake;
    logic take_beat;
    logic [`XGMII_DATA_W-1:0] beat_masked;
    logic [`XGMII_DATA_W-1:0] held_data_next;
    logic [2:0] keep_empty;
    logic [2:0] held_empty_next;
    logic [7:0] min_in;
    logic [7:0] min_count;
    logic [7:0] min_count_next;
    logic [15:0] frame_len;
    logic [15:0] frame_len_next;
    logic [7:0] gap;
    logic [7:0] ifg_count;
    logic [7:0] ifg_count_next;
    logic err_user;
    logic err_user_next;
    logic err_underflow;
    logic err_underflow_next;
    xgmii_word_t xgmii_next;
    tx_stat_t stat_next;

    // keep is contiguous from lane 0
    function automatic logic [2:0] keep_to_empty(input logic [`XGMII_CTRL_W-1:0] keep);
        int n;
        n = 1;
        for (int i = 0; i < `XGMII_CTRL_W; i++) begin
            if (keep[i]) begin
                n = i + 1;
            end
        end
        return 3'(`XGMII_CTRL_W - n);
    endfunction

    always_comb begin
        for (int i = 0; i < `XGMII_CTRL_W; i++) begin
            beat_masked[8*i +: 8] = s_beat.keep[i] ? s_beat.data[8*i +: 8] : 8'h00;
        end
    end

    assign keep_empty = keep_to_empty(s_beat.keep);
    assign handshake = s_valid && s_ready;
    assign gap = (tx_ifg > 8'(`ETH_MIN_IFG)) ? tx_ifg : 8'(`ETH_MIN_IFG);

    always_comb begin
        state_next = state;
        frame_open_next = frame_open;
        ready_next = 1'b0;
        crc_init = 1'b0;
        crc_update = 1'b0;
        take_beat = 1'b0;
        held_data_next = held_data;
        held_empty_next = held_empty;
        min_in = min_count;
        frame_len_next = frame_len + 16'(word_bytes);
        ifg_count_next = ifg_count;
        err_user_next = err_user;
        err_underflow_next = err_underflow;
        xgmii_next = idle_word;
        stat_next = '0;

        if (handshake) begin
            frame_open_next = !s_beat.last;
        end

        case (state)
            st_idle: begin
                crc_init = 1'b1;
                ready_next = tx_enable;
                frame_len_next = '0;
                if (handshake) begin
                    xgmii_next.txd = {`ETH_SFD, {6{`ETH_PRE}}, xgmii_start};
                    xgmii_next.txc = 8'h01;
                    min_in = min_payload;
                    take_beat = 1'b1;
                end
            end
            st_payload: begin
                crc_update = 1'b1;
                xgmii_next.txd = held_data;
                xgmii_next.txc = '0;
                take_beat = 1'b1;
            end
            st_pad: begin
                crc_update = 1'b1;
                ready_next = frame_open_next;
                xgmii_next.txd = held_data;
                xgmii_next.txc = '0;
                held_data_next = '0;
                held_empty_next = '0;
                if (min_count <= word_bytes) begin
                    held_empty_next = 3'(word_bytes - min_count);
                    state_next = st_fcs_1;
                end
            end
            st_fcs_1: begin
                crc_update = 1'b1;
                ready_next = frame_open_next;
                xgmii_next = fcs.word_0;
                if (held_empty <= 3'd4) begin
                    state_next = st_fcs_2;
                end else begin
                    stat_next.pkt_len = frame_len + 16'd12 - 16'(held_empty);
                    stat_next.pkt_good = 1'b1;
                    stat_next.valid = 1'b1;
                    ifg_count_next = gap - 8'(fcs.ifg_offset) + 8'd1;
                    state_next = st_ifg;
                end
            end
            st_fcs_2: begin
                ready_next = frame_open_next;
                xgmii_next = fcs.word_1;
                stat_next.pkt_len = frame_len + 16'd4 - 16'(held_empty);
                stat_next.pkt_good = 1'b1;
                stat_next.valid = 1'b1;
                ifg_count_next = gap - 8'(fcs.ifg_offset) + 8'd1;
                state_next = st_ifg;
            end
            st_err: begin
                ready_next = frame_open_next;
                xgmii_next.txd = {xgmii_term, {7{xgmii_error}}};
                xgmii_next.txc = '1;
                stat_next.pkt_len = frame_len;
                stat_next.pkt_bad = 1'b1;
                stat_next.err_user = err_user;
                stat_next.err_underflow = err_underflow;
                stat_next.valid = 1'b1;
                // terminate sits in lane 7, no idle lanes behind it
                ifg_count_next = gap;
                state_next = st_ifg;
            end
            st_ifg: begin
                ready_next = frame_open_next;
                ifg_count_next = (ifg_count > word_bytes) ? ifg_count - word_bytes : '0;
                // stay until the gap is served and any dropped frame has drained
                if (ifg_count_next == '0 && !frame_open_next) begin
                    ready_next = tx_enable;
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase

        min_count_next = (min_in > word_bytes) ? min_in - word_bytes : '0;

        // decide what the incoming beat does to the frame
        if (take_beat) begin
            held_data_next = beat_masked;
            held_empty_next = keep_empty;
            ready_next = 1'b1;
            state_next = st_payload;
            if (!s_valid || s_beat.user) begin
                ready_next = frame_open_next;
                err_user_next = s_valid && s_beat.user;
                err_underflow_next = !s_valid;
                state_next = st_err;
            end else if (s_beat.last) begin
                ready_next = 1'b0;
                if (min_in > word_bytes) begin
                    // masked lanes are already zero padding
                    held_empty_next = '0;
                    state_next = st_pad;
                end else begin
                    if (min_in != '0 && keep_empty > 3'(word_bytes - min_in)) begin
                        held_empty_next = 3'(word_bytes - min_in);
                    end
                    state_next = st_fcs_1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= st_idle;
            frame_open <= 1'b0;
            s_ready <= 1'b0;
            ifg_count <= '0;
            xgmii <= idle_word;
            stat <= '0;
        end else begin
            state <= state_next;
            frame_open <= frame_open_next;
            s_ready <= ready_next;
            ifg_count <= ifg_count_next;
            xgmii <= xgmii_next;
            stat <= stat_next;
        end
    end

    always_ff @(posedge clk) begin
        held_data <= held_data_next;
        held_empty <= held_empty_next;
        min_count <= min_count_next;
        frame_len <= frame_len_next;
        err_user <= err_user_next;
        err_underflow <= err_underflow_next;
    end

    assert property (@(posedge clk) disable iff (reset_crc) !$isunknown(xgmii.txc))
        else $error("xgmii txc unknown");

    assert property (@(posedge clk) disable iff (reset_crc) !(stat.pkt_good && stat.pkt_bad))
        else $error("frame reported good and bad together");

endmodule

// ==== source/xgmii_tx_macros.svh ====
// data and control widths, frame limits, CRC constants and preamble bytes
`ifndef XGMII_TX_MACROS_SVH
`define XGMII_TX_MACROS_SVH

// XGMII word geometry
`define XGMII_DATA_W 64
`define XGMII_CTRL_W 8

// frame limits in bytes, FCS included
`define ETH_MIN_FRAME_LEN 64
`define ETH_MIN_IFG 12

// preamble and start frame delimiter
`define ETH_PRE 8'h55
`define ETH_SFD 8'hD5

// reflected form of 0x04C11DB7
`define ETH_CRC_POLY 32'hEDB88320
`define ETH_CRC_INIT 32'hFFFFFFFF

`endif

// ==== source/xgmii_tx_pkg.sv ====
// input beat, XGMII word, line character, FSM state, CRC lane, FCS and status types
`include "xgmii_tx_macros.svh"

package xgmii_tx_pkg;

    typedef struct packed {
        logic [`XGMII_DATA_W-1:0] data;
        logic [`XGMII_CTRL_W-1:0] keep;
        logic                     last;
        logic                     user;
    } tx_beat_t;

    typedef struct packed {
        logic [`XGMII_DATA_W-1:0] txd;
        logic [`XGMII_CTRL_W-1:0] txc;
    } xgmii_word_t;

    typedef enum logic [7:0] {
        xgmii_idle  = 8'h07,
        xgmii_start = 8'hFB,
        xgmii_term  = 8'hFD,
        xgmii_error = 8'hFE
    } xgmii_char_e;

    typedef enum logic [2:0] {
        st_idle,
        st_payload,
        st_pad,
        st_fcs_1,
        st_fcs_2,
        st_err,
        st_ifg
    } tx_state_e;

    // entry n is the CRC after n+1 bytes of the word
    typedef logic [7:0][31:0] crc_lanes_t;

    typedef struct packed {
        xgmii_word_t word_0;
        xgmii_word_t word_1;
        logic [3:0]  ifg_offset;
    } fcs_words_t;

    typedef struct packed {
        logic [15:0] pkt_len;
        logic        pkt_good;
        logic        pkt_bad;
        logic        err_user;
        logic        err_underflow;
        logic        valid;
    } tx_stat_t;

endpackage

// ==== source/xgmii_tx_top.sv ====
// transmitter top with framing controller, CRC engine and FCS merge
`timescale 1ns/1ps
`include "xgmii_tx_macros.svh"

module xgmii_tx_top
    import xgmii_tx_pkg::*;
(
    input  logic        clk,
    input  logic        reset_crc,
    input  tx_beat_t    s_beat,
    input  logic        s_valid,
    output logic        s_ready,
    input  logic [7:0]  tx_ifg,
    input  logic        tx_enable,
    output xgmii_word_t xgmii,
    output tx_stat_t    stat
);

    logic [`XGMII_DATA_W-1:0] held_data;
    logic [2:0] held_empty;
    logic crc_init;
    logic crc_update;
    crc_lanes_t crc_next;
    crc_lanes_t crc_held;
    fcs_words_t fcs;

    xgmii_tx_ctrl xgmii_tx_ctrl_inst (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .tx_ifg     (tx_ifg),
        .tx_enable  (tx_enable),
        .held_data  (held_data),
        .held_empty (held_empty),
        .crc_init   (crc_init),
        .crc_update (crc_update),
        .fcs        (fcs),
        .xgmii      (xgmii),
        .stat       (stat)
    );

    eth_crc32 eth_crc32_inst (
        .clk        (clk),
        .crc_init   (crc_init),
        .crc_update (crc_update),
        .data       (held_data),
        .crc_next   (crc_next),
        .crc_held   (crc_held)
    );

    xgmii_fcs_merge xgmii_fcs_merge_inst (
        .data       (held_data),
        .empty      (held_empty),
        .crc_next   (crc_next),
        .crc_held   (crc_held),
        .fcs        (fcs)
    );

endmodule

// ==== xgmii_tx_top.f ====
+incdir+source
source/xgmii_tx_pkg.sv
source/eth_crc32.sv
source/xgmii_fcs_merge.sv
source/xgmii_tx_ctrl.sv
source/xgmii_tx_top.sv
dv/xgmii_tx_tb.sv
